// File: Bender.yml
package:
  name: rv32i_core

sources:
  - rv_pkg.sv
  - id_ex_if.sv
  - fetch_unit.sv
  - regfile.sv
  - decode_unit.sv
  - execute_unit.sv
  - mem_wb_unit.sv
  - hazard_unit.sv
  - core_top.sv
  - target: simulation
    files:
      - core_asserts.sv
      - tb_core.sv

// File: core_asserts.sv
module core_asserts import rv_pkg::*; (
    input logic  clk,
    input logic  i_reset,
    input word_t i_imem_addr,
    input logic  i_imem_ack,
    input logic  i_dmem_req,
    input logic  i_dmem_we,
    input word_t i_dmem_addr,
    input word_t i_dmem_wdata,
    input logic  i_dmem_ack
);

    int unsigned fail_count = 0;

    a_pc_after_reset: assert property (@(posedge clk)
        $fell(i_reset) |-> i_imem_addr == RESET_PC && !i_dmem_req && !i_dmem_we)
    else begin
        $error("PC or data port wrong after reset");
        fail_count++;
    end

    a_pc_aligned: assert property (@(posedge clk) disable iff (i_reset)
        i_imem_addr[1:0] == 2'b00)
    else begin
        $error("instruction address not word aligned");
        fail_count++;
    end

    a_imem_stable: assert property (@(posedge clk) disable iff (i_reset)
        !i_imem_ack |=> $stable(i_imem_addr))
    else begin
        $error("instruction address moved without an ack");
        fail_count++;
    end

    // Request held with stable address and data until acked
    a_dmem_stable: assert property (@(posedge clk) disable iff (i_reset)
        i_dmem_req && !i_dmem_ack |=> i_dmem_req && $stable(i_dmem_addr) &&
            $stable(i_dmem_we) && $stable(i_dmem_wdata))
    else begin
        $error("data request changed before its ack");
        fail_count++;
    end

endmodule

bind core_top core_asserts asserts0 (
    .clk          (clk),
    .i_reset      (i_reset),
    .i_imem_addr  (o_imem_addr),
    .i_imem_ack   (i_imem_ack),
    .i_dmem_req   (o_dmem_req),
    .i_dmem_we    (o_dmem_we),
    .i_dmem_addr  (o_dmem_addr),
    .i_dmem_wdata (o_dmem_wdata),
    .i_dmem_ack   (i_dmem_ack)
);

// File: core_top.sv
module core_top import rv_pkg::*; (
    input  logic  clk,
    input  logic  i_reset,

    // Instruction port
    output word_t o_imem_addr,
    input  word_t i_imem_instr,
    input  logic  i_imem_ack,

    // Data port
    output logic  o_dmem_req,
    output logic  o_dmem_we,
    output word_t o_dmem_addr,
    output word_t o_dmem_wdata,
    input  word_t i_dmem_rdata,
    input  logic  i_dmem_ack
);

    word_t     pc;
    logic      if_valid;
    word_t     if_pc;
    word_t     if_instr;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     rs1_data;
    word_t     rs2_data;
    fwd_sel_e  fwd_a;
    fwd_sel_e  fwd_b;
    word_t     ex_result;
    logic      redirect;
    word_t     redirect_pc;
    logic      mem_valid;
    word_t     mem_result;
    word_t     mem_wdata;
    reg_addr_t mem_rd;
    logic      mem_is_load;
    logic      mem_is_store;
    logic      mem_wr_reg;
    word_t     mem_fwd_data;
    logic      wb_we;
    reg_addr_t wb_addr;
    word_t     wb_data;
    logic      stall;
    logic      flush;
    logic      hold;

    id_ex_if ex_bus ();

    fetch_unit fetch_unit_inst (
        .clk           (clk),
        .i_reset       (i_reset),
        .i_hold        (hold),
        .i_stall       (stall),
        .i_flush       (flush),
        .i_redirect    (redirect),
        .i_redirect_pc (redirect_pc),
        .i_instr       (i_imem_instr),
        .o_pc          (pc),
        .o_if_valid    (if_valid),
        .o_if_pc       (if_pc),
        .o_if_instr    (if_instr)
    );
    assign o_imem_addr = pc;

    decode_unit decode_unit_inst (
        .clk        (clk),
        .i_reset    (i_reset),
        .i_hold     (hold),
        .i_stall    (stall),
        .i_flush    (flush),
        .i_if_valid (if_valid),
        .i_if_pc    (if_pc),
        .i_if_instr (if_instr),
        .o_rs1      (rs1),
        .o_rs2      (rs2),
        .i_rs1_data (rs1_data),
        .i_rs2_data (rs2_data),
        .i_fwd_a    (fwd_a),
        .i_fwd_b    (fwd_b),
        .i_ex_data  (ex_result),
        .i_mem_data (mem_fwd_data),
        .ex_bus     (ex_bus.producer)
    );

    regfile regfile_inst (
        .clk        (clk),
        .i_reset    (i_reset),
        .i_rs1      (rs1),
        .i_rs2      (rs2),
        .i_we       (wb_we),
        .i_waddr    (wb_addr),
        .i_wdata    (wb_data),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    execute_unit execute_unit_inst (
        .clk            (clk),
        .i_reset        (i_reset),
        .i_hold         (hold),
        .ex_bus         (ex_bus.consumer),
        .o_ex_result    (ex_result),
        .o_redirect     (redirect),
        .o_redirect_pc  (redirect_pc),
        .o_mem_valid    (mem_valid),
        .o_mem_result   (mem_result),
        .o_mem_wdata    (mem_wdata),
        .o_mem_rd       (mem_rd),
        .o_mem_is_load  (mem_is_load),
        .o_mem_is_store (mem_is_store),
        .o_mem_wr_reg   (mem_wr_reg)
    );

    mem_wb_unit mem_wb_unit_inst (
        .clk            (clk),
        .i_reset        (i_reset),
        .i_hold         (hold),
        .i_mem_valid    (mem_valid),
        .i_mem_result   (mem_result),
        .i_mem_wdata    (mem_wdata),
        .i_mem_rd       (mem_rd),
        .i_mem_is_load  (mem_is_load),
        .i_mem_is_store (mem_is_store),
        .i_mem_wr_reg   (mem_wr_reg),
        .o_dmem_req     (o_dmem_req),
        .o_dmem_we      (o_dmem_we),
        .o_dmem_addr    (o_dmem_addr),
        .o_dmem_wdata   (o_dmem_wdata),
        .i_dmem_rdata   (i_dmem_rdata),
        .i_dmem_ack     (i_dmem_ack),
        .o_mem_fwd_data (mem_fwd_data),
        .o_wb_we        (wb_we),
        .o_wb_addr      (wb_addr),
        .o_wb_data      (wb_data)
    );

    hazard_unit hazard_unit_inst (
        .i_rs1        (rs1),
        .i_rs2        (rs2),
        .ex_bus       (ex_bus.consumer),
        .i_mem_rd     (mem_rd),
        .i_mem_wr_reg (mem_wr_reg),
        .i_redirect   (redirect),
        .i_imem_ack   (i_imem_ack),
        .i_dmem_req   (o_dmem_req),
        .i_dmem_ack   (i_dmem_ack),
        .o_fwd_a      (fwd_a),
        .o_fwd_b      (fwd_b),
        .o_stall      (stall),
        .o_flush      (flush),
        .o_hold       (hold)
    );

endmodule

// File: decode_unit.sv
module decode_unit import rv_pkg::*; (
    input  logic      clk,
    input  logic      i_reset,
    input  logic      i_hold,
    input  logic      i_stall,
    input  logic      i_flush,
    input  logic      i_if_valid,
    input  word_t     i_if_pc,
    input  word_t     i_if_instr,
    output reg_addr_t o_rs1,
    output reg_addr_t o_rs2,
    input  word_t     i_rs1_data,
    input  word_t     i_rs2_data,
    input  fwd_sel_e  i_fwd_a,
    input  fwd_sel_e  i_fwd_b,
    input  word_t     i_ex_data,
    input  word_t     i_mem_data,
    id_ex_if.producer ex_bus
);

    opcode_t    opcode;
    logic [2:0] funct3;
    word_t      imm;
    alu_op_e    alu_op;
    logic       use_imm;
    logic       is_load;
    logic       is_store;
    logic       is_branch;
    logic       is_jal;
    logic       wr_reg;
    logic       uses_rs1;
    logic       uses_rs2;
    logic       kill;
    word_t      op_a;
    word_t      op_b;

    function automatic alu_op_e alu_from_funct3(logic [2:0] f3, logic sub);
        case (f3)
            3'b000:  return sub ? ALU_SUB : ALU_ADD;
            3'b010:  return ALU_SLT;
            3'b100:  return ALU_XOR;
            3'b110:  return ALU_OR;
            3'b111:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    function automatic word_t pick_operand(fwd_sel_e sel, word_t rf_data);
        case (sel)
            FWD_EX:  return i_ex_data;
            FWD_MEM: return i_mem_data;
            default: return rf_data;
        endcase
    endfunction

    assign opcode = i_if_instr[6:0];
    assign funct3 = i_if_instr[14:12];

    always_comb begin
        imm       = {{20{i_if_instr[31]}}, i_if_instr[31:20]};
        alu_op    = ALU_ADD;
        use_imm   = 1'b0;
        is_load   = 1'b0;
        is_store  = 1'b0;
        is_branch = 1'b0;
        is_jal    = 1'b0;
        wr_reg    = 1'b0;
        uses_rs1  = 1'b0;
        uses_rs2  = 1'b0;
        case (opcode)
            OP_LUI: begin
                imm     = {i_if_instr[31:12], 12'b0};
                alu_op  = ALU_PASSB;
                use_imm = 1'b1;
                wr_reg  = 1'b1;
            end
            OP_IMM: begin
                alu_op   = alu_from_funct3(funct3, 1'b0);
                use_imm  = 1'b1;
                wr_reg   = 1'b1;
                uses_rs1 = 1'b1;
            end
            OP_REG: begin
                alu_op   = alu_from_funct3(funct3, i_if_instr[30]);
                wr_reg   = 1'b1;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            OP_LOAD: begin
                use_imm  = 1'b1;
                is_load  = 1'b1;
                wr_reg   = 1'b1;
                uses_rs1 = 1'b1;
            end
            OP_STORE: begin
                imm      = {{20{i_if_instr[31]}}, i_if_instr[31:25], i_if_instr[11:7]};
                use_imm  = 1'b1;
                is_store = 1'b1;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            OP_BRANCH: begin
                imm       = {{19{i_if_instr[31]}}, i_if_instr[31], i_if_instr[7],
                             i_if_instr[30:25], i_if_instr[11:8], 1'b0};
                is_branch = 1'b1;
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
            end
            OP_JAL: begin
                imm    = {{11{i_if_instr[31]}}, i_if_instr[31], i_if_instr[19:12],
                          i_if_instr[20], i_if_instr[30:21], 1'b0};
                is_jal = 1'b1;
                wr_reg = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // Unused source fields read as x0 so they never forward or stall
    assign o_rs1 = (i_if_valid && uses_rs1) ? i_if_instr[19:15] : '0;
    assign o_rs2 = (i_if_valid && uses_rs2) ? i_if_instr[24:20] : '0;

    always_comb op_a = pick_operand(i_fwd_a, i_rs1_data);
    always_comb op_b = pick_operand(i_fwd_b, i_rs2_data);

    assign kill = i_stall | i_flush | ~i_if_valid;

    // ID/EX register
    always_ff @(posedge clk) begin
        if (i_reset) begin
            ex_bus.valid     <= 1'b0;
            ex_bus.is_load   <= 1'b0;
            ex_bus.is_store  <= 1'b0;
            ex_bus.is_branch <= 1'b0;
            ex_bus.is_jal    <= 1'b0;
            ex_bus.wr_reg    <= 1'b0;
        end else if (!i_hold) begin
            ex_bus.valid     <= ~kill;
            ex_bus.is_load   <= is_load & ~kill;
            ex_bus.is_store  <= is_store & ~kill;
            ex_bus.is_branch <= is_branch & ~kill;
            ex_bus.is_jal    <= is_jal & ~kill;
            ex_bus.wr_reg    <= wr_reg & ~kill;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_hold) begin
            ex_bus.pc        <= i_if_pc;
            ex_bus.op_a      <= op_a;
            ex_bus.op_b_reg  <= op_b;
            ex_bus.imm       <= imm;
            ex_bus.rd        <= i_if_instr[11:7];
            ex_bus.alu_op    <= alu_op;
            ex_bus.use_imm   <= use_imm;
            ex_bus.branch_ne <= funct3[0];
        end
    end

endmodule

// File: execute_unit.sv
module execute_unit import rv_pkg::*; (
    input  logic      clk,
    input  logic      i_reset,
    input  logic      i_hold,
    id_ex_if.consumer ex_bus,
    output word_t     o_ex_result,
    output logic      o_redirect,
    output word_t     o_redirect_pc,
    output logic      o_mem_valid,
    output word_t     o_mem_result,
    output word_t     o_mem_wdata,
    output reg_addr_t o_mem_rd,
    output logic      o_mem_is_load,
    output logic      o_mem_is_store,
    output logic      o_mem_wr_reg
);

    word_t alu_b;
    word_t alu_out;
    logic  taken;

    assign alu_b = ex_bus.use_imm ? ex_bus.imm : ex_bus.op_b_reg;

    always_comb begin
        case (ex_bus.alu_op)
            ALU_SUB:   alu_out = ex_bus.op_a - alu_b;
            ALU_AND:   alu_out = ex_bus.op_a & alu_b;
            ALU_OR:    alu_out = ex_bus.op_a | alu_b;
            ALU_XOR:   alu_out = ex_bus.op_a ^ alu_b;
            ALU_SLT:   alu_out = {31'b0, $signed(ex_bus.op_a) < $signed(alu_b)};
            ALU_PASSB: alu_out = alu_b;
            default:   alu_out = ex_bus.op_a + alu_b;
        endcase
    end

    // JAL links the return address instead of the ALU value
    assign o_ex_result = ex_bus.is_jal ? ex_bus.pc + 32'd4 : alu_out;

    // BEQ and BNE share one comparator
    assign taken = ex_bus.is_branch &&
                   ((ex_bus.op_a == ex_bus.op_b_reg) != ex_bus.branch_ne);

    assign o_redirect    = ex_bus.valid && (ex_bus.is_jal || taken);
    assign o_redirect_pc = ex_bus.pc + ex_bus.imm;

    // EX/MEM register
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_mem_valid    <= 1'b0;
            o_mem_is_load  <= 1'b0;
            o_mem_is_store <= 1'b0;
            o_mem_wr_reg   <= 1'b0;
        end else if (!i_hold) begin
            o_mem_valid    <= ex_bus.valid;
            o_mem_is_load  <= ex_bus.is_load;
            o_mem_is_store <= ex_bus.is_store;
            o_mem_wr_reg   <= ex_bus.wr_reg;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_hold) begin
            o_mem_result <= o_ex_result;
            o_mem_wdata  <= ex_bus.op_b_reg;
            o_mem_rd     <= ex_bus.rd;
        end
    end

endmodule

// File: fetch_unit.sv
module fetch_unit import rv_pkg::*; (
    input  logic  clk,
    input  logic  i_reset,
    input  logic  i_hold,
    input  logic  i_stall,
    input  logic  i_flush,
    input  logic  i_redirect,
    input  word_t i_redirect_pc,
    input  word_t i_instr,
    output word_t o_pc,
    output logic  o_if_valid,
    output word_t o_if_pc,
    output word_t o_if_instr
);

    word_t pc_q;

    assign o_pc = pc_q;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            pc_q <= RESET_PC;
        end else if (!i_hold) begin
            if (i_redirect) begin
                pc_q <= i_redirect_pc;
            end else if (!i_stall) begin
                pc_q <= pc_q + 32'd4;
            end
        end
    end

    // IF/ID register
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_if_valid <= 1'b0;
        end else if (!i_hold) begin
            if (i_flush) begin
                o_if_valid <= 1'b0;
            end else if (!i_stall) begin
                o_if_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!i_hold && !i_stall) begin
            o_if_pc    <= pc_q;
            o_if_instr <= i_instr;
        end
    end

endmodule

// File: hazard_unit.sv
module hazard_unit import rv_pkg::*; (
    input  reg_addr_t i_rs1,
    input  reg_addr_t i_rs2,
    id_ex_if.consumer ex_bus,
    input  reg_addr_t i_mem_rd,
    input  logic      i_mem_wr_reg,
    input  logic      i_redirect,
    input  logic      i_imem_ack,
    input  logic      i_dmem_req,
    input  logic      i_dmem_ack,
    output fwd_sel_e  o_fwd_a,
    output fwd_sel_e  o_fwd_b,
    output logic      o_stall,
    output logic      o_flush,
    output logic      o_hold
);

    logic ex_hit_rs1;
    logic ex_hit_rs2;

    // The younger producer in EX wins over MEM
    function automatic fwd_sel_e pick_source(reg_addr_t rs);
        if (rs == '0) begin
            return FWD_RF;
        end
        if (ex_bus.wr_reg && ex_bus.rd == rs) begin
            return FWD_EX;
        end
        if (i_mem_wr_reg && i_mem_rd == rs) begin
            return FWD_MEM;
        end
        return FWD_RF;
    endfunction

    always_comb o_fwd_a = pick_source(i_rs1);
    always_comb o_fwd_b = pick_source(i_rs2);

    assign ex_hit_rs1 = (i_rs1 != '0) && (ex_bus.rd == i_rs1);
    assign ex_hit_rs2 = (i_rs2 != '0) && (ex_bus.rd == i_rs2);

    // Load data is not ready until MEM
    assign o_stall = ex_bus.is_load && ex_bus.wr_reg && (ex_hit_rs1 || ex_hit_rs2);
    assign o_flush = i_redirect;

    assign o_hold = ~i_imem_ack | (i_dmem_req & ~i_dmem_ack);

endmodule

// File: id_ex_if.sv
interface id_ex_if import rv_pkg::*; ();

    logic      valid;
    word_t     pc;
    word_t     op_a;
    word_t     op_b_reg;
    word_t     imm;
    reg_addr_t rd;
    alu_op_e   alu_op;
    logic      use_imm;
    logic      is_load;
    logic      is_store;
    logic      is_branch;
    logic      branch_ne;
    logic      is_jal;
    logic      wr_reg;

    modport producer (
        output valid, pc, op_a, op_b_reg, imm, rd, alu_op, use_imm,
               is_load, is_store, is_branch, branch_ne, is_jal, wr_reg
    );

    modport consumer (
        input valid, pc, op_a, op_b_reg, imm, rd, alu_op, use_imm,
              is_load, is_store, is_branch, branch_ne, is_jal, wr_reg
    );

endinterface

// File: mem_wb_unit.sv
module mem_wb_unit import rv_pkg::*; (
    input  logic      clk,
    input  logic      i_reset,
    input  logic      i_hold,
    input  logic      i_mem_valid,
    input  word_t     i_mem_result,
    input  word_t     i_mem_wdata,
    input  reg_addr_t i_mem_rd,
    input  logic      i_mem_is_load,
    input  logic      i_mem_is_store,
    input  logic      i_mem_wr_reg,
    output logic      o_dmem_req,
    output logic      o_dmem_we,
    output word_t     o_dmem_addr,
    output word_t     o_dmem_wdata,
    input  word_t     i_dmem_rdata,
    input  logic      i_dmem_ack,
    output word_t     o_mem_fwd_data,
    output logic      o_wb_we,
    output reg_addr_t o_wb_addr,
    output word_t     o_wb_data
);

    logic  done_q;
    word_t rdata_q;
    word_t load_data;

    // An access acked while the fetch side still holds is not issued twice
    assign o_dmem_req   = i_mem_valid & (i_mem_is_load | i_mem_is_store) & ~done_q;
    assign o_dmem_we    = o_dmem_req & i_mem_is_store;
    assign o_dmem_addr  = i_mem_result;
    assign o_dmem_wdata = i_mem_wdata;

    always_ff @(posedge clk) begin
        if (i_reset || !i_hold) begin
            done_q <= 1'b0;
        end else if (o_dmem_req && i_dmem_ack) begin
            done_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (o_dmem_req && i_dmem_ack) begin
            rdata_q <= i_dmem_rdata;
        end
    end

    assign load_data      = done_q ? rdata_q : i_dmem_rdata;
    assign o_mem_fwd_data = i_mem_is_load ? load_data : i_mem_result;

    // MEM/WB register
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_wb_we <= 1'b0;
        end else if (!i_hold) begin
            o_wb_we <= i_mem_valid & i_mem_wr_reg;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_hold) begin
            o_wb_addr <= i_mem_rd;
            o_wb_data <= o_mem_fwd_data;
        end
    end

endmodule

// File: regfile.sv
module regfile import rv_pkg::*; (
    input  logic      clk,
    input  logic      i_reset,
    input  reg_addr_t i_rs1,
    input  reg_addr_t i_rs2,
    input  logic      i_we,
    input  reg_addr_t i_waddr,
    input  word_t     i_wdata,
    output word_t     o_rs1_data,
    output word_t     o_rs2_data
);

    word_t regs [1:31];

    // x0 reads zero, a same-cycle write wins over the stored value
    function automatic word_t read_port(reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (i_we && addr == i_waddr) begin
            return i_wdata;
        end
        return regs[addr];
    endfunction

    always_comb o_rs1_data = read_port(i_rs1);
    always_comb o_rs2_data = read_port(i_rs2);

    always_ff @(posedge clk) begin
        if (i_reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_waddr != '0) begin
            regs[i_waddr] <= i_wdata;
        end
    end

endmodule

// File: rv_pkg.sv
package rv_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [6:0]      opcode_t;

    // Major opcodes of the supported RV32I subset
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_REG    = 7'b0110011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JAL    = 7'b1101111;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASSB
    } alu_op_e;

    // Where an ID operand comes from
    typedef enum logic [1:0] {
        FWD_RF,
        FWD_EX,
        FWD_MEM
    } fwd_sel_e;

    localparam word_t RESET_PC = '0;

endpackage

// File: sources.f
rv_pkg.sv
id_ex_if.sv
fetch_unit.sv
regfile.sv
decode_unit.sv
execute_unit.sv
mem_wb_unit.sv
hazard_unit.sv
core_top.sv
core_asserts.sv
tb_core.sv

// File: tb_core.sv
module tb_core import rv_pkg::*; ();

    localparam word_t END_PC        = 32'h0000_00A0;
    localparam int    STORE_TIMEOUT = 2000;
    localparam int    DRAIN_TIMEOUT = 400;
    localparam int    DRAIN_CYCLES  = 12;

    logic  clk;
    logic  i_reset;
    word_t o_imem_addr;
    word_t i_imem_instr;
    logic  i_imem_ack;
    logic  o_dmem_req;
    logic  o_dmem_we;
    word_t o_dmem_addr;
    word_t o_dmem_wdata;
    word_t i_dmem_rdata;
    logic  i_dmem_ack;

    word_t rom [0:63];
    word_t ram [0:255];
    int    prog_len;
    word_t exp_addr [$];
    word_t exp_data [$];
    int    store_idx;
    int    errors;
    int    timeouts;
    word_t imem_last;
    int    imem_wait;
    logic  dmem_pending;
    int    dmem_wait;

    core_top dut0 (
        .clk          (clk),
        .i_reset      (i_reset),
        .o_imem_addr  (o_imem_addr),
        .i_imem_instr (i_imem_instr),
        .i_imem_ack   (i_imem_ack),
        .o_dmem_req   (o_dmem_req),
        .o_dmem_we    (o_dmem_we),
        .o_dmem_addr  (o_dmem_addr),
        .o_dmem_wdata (o_dmem_wdata),
        .i_dmem_rdata (i_dmem_rdata),
        .i_dmem_ack   (i_dmem_ack)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // RV32I encodings
    function automatic word_t alu_imm_instr(logic [2:0] f3, logic [4:0] rd, logic [4:0] rs1,
                                            logic [31:0] imm);
        return {imm[11:0], rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic word_t alu_reg_instr(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                            logic [4:0] rs1, logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t load_instr(logic [4:0] rd, logic [4:0] rs1, logic [31:0] imm);
        return {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic word_t store_instr(logic [4:0] rs2, logic [4:0] rs1, logic [31:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t branch_instr(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                           logic [31:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic word_t jal_instr(logic [4:0] rd, logic [31:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic word_t lui_instr(logic [4:0] rd, logic [19:0] upper);
        return {upper, rd, 7'b0110111};
    endfunction

    function automatic word_t ram_fill(word_t addr);
        return addr ^ 32'hDEAD_0000;
    endfunction

    task automatic place_instr(word_t instr);
        rom[prog_len] = instr;
        prog_len++;
    endtask

    task automatic expect_store(word_t addr, word_t data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic check_store(word_t addr, word_t data);
        assert (store_idx < exp_addr.size()) else begin
            $display("Store %0d to address %08h was not expected", store_idx, addr);
            errors++;
        end
        if (store_idx < exp_addr.size()) begin
            assert (addr == exp_addr[store_idx]) else begin
                $display("MISMATCH o_dmem_addr: got %08h expected %08h",
                         addr, exp_addr[store_idx]);
                errors++;
            end
            assert (data == exp_data[store_idx]) else begin
                $display("MISMATCH o_dmem_wdata: got %08h expected %08h",
                         data, exp_data[store_idx]);
                errors++;
            end
        end
        store_idx++;
    endtask

    task automatic build_program();
        place_instr(alu_imm_instr(3'b000, 1, 0, 5));
        place_instr(alu_imm_instr(3'b000, 2, 0, -3));
        // Operands from EX and MEM together
        place_instr(alu_reg_instr(7'b0000000, 3'b000, 3, 1, 2));
        place_instr(alu_reg_instr(7'b0100000, 3'b000, 4, 1, 2));
        place_instr(alu_reg_instr(7'b0000000, 3'b010, 5, 2, 1));
        place_instr(lui_instr(6, 20'h12345));
        place_instr(alu_imm_instr(3'b100, 7, 6, 32'h0F0));
        place_instr(alu_imm_instr(3'b111, 8, 7, 32'h7FF));
        place_instr(alu_imm_instr(3'b110, 9, 8, 32'h300));
        place_instr(store_instr(3, 0, 32'h100));
        place_instr(store_instr(4, 0, 32'h104));
        place_instr(store_instr(5, 0, 32'h108));
        place_instr(store_instr(7, 0, 32'h10C));
        place_instr(store_instr(9, 0, 32'h110));
        place_instr(alu_reg_instr(7'b0000000, 3'b111, 11, 7, 6));
        place_instr(alu_reg_instr(7'b0000000, 3'b110, 12, 2, 1));
        place_instr(alu_reg_instr(7'b0000000, 3'b100, 13, 12, 11));
        place_instr(alu_imm_instr(3'b010, 14, 2, 0));
        place_instr(store_instr(13, 0, 32'h114));
        place_instr(store_instr(14, 0, 32'h118));
        // Load-use pairs
        place_instr(load_instr(15, 0, 32'h100));
        place_instr(alu_reg_instr(7'b0000000, 3'b000, 16, 15, 1));
        place_instr(store_instr(16, 0, 32'h11C));
        place_instr(load_instr(17, 0, 32'h180));
        place_instr(alu_imm_instr(3'b000, 18, 17, 1));
        place_instr(store_instr(18, 0, 32'h120));
        // Shadow stores of a taken BEQ must vanish
        place_instr(branch_instr(3'b000, 1, 1, 12));
        place_instr(store_instr(1, 0, 32'h1E0));
        place_instr(store_instr(2, 0, 32'h1E4));
        place_instr(branch_instr(3'b001, 3, 15, 12));
        place_instr(store_instr(4, 0, 32'h124));
        place_instr(jal_instr(19, 12));
        place_instr(store_instr(1, 0, 32'h1E8));
        place_instr(store_instr(2, 0, 32'h1EC));
        place_instr(store_instr(19, 0, 32'h128));
        place_instr(branch_instr(3'b000, 1, 2, 8));
        place_instr(branch_instr(3'b001, 1, 2, 12));
        place_instr(store_instr(1, 0, 32'h1E0));
        place_instr(store_instr(1, 0, 32'h1E4));
        place_instr(store_instr(1, 0, 32'h12C));
        place_instr(jal_instr(0, 0));
    endtask

    task automatic build_expected();
        expect_store(32'h100, 32'd5 + 32'hFFFF_FFFD);
        expect_store(32'h104, 32'd5 - 32'hFFFF_FFFD);
        expect_store(32'h108, 32'd1);
        expect_store(32'h10C, 32'h1234_5000 ^ 32'h0F0);
        expect_store(32'h110, ((32'h1234_5000 ^ 32'h0F0) & 32'h7FF) | 32'h300);
        expect_store(32'h114, (32'hFFFF_FFFD | 32'd5) ^ (32'h1234_50F0 & 32'h1234_5000));
        expect_store(32'h118, 32'd1);
        expect_store(32'h11C, 32'd2 + 32'd5);
        expect_store(32'h120, ram_fill(32'h180) + 32'd1);
        expect_store(32'h124, 32'd8);
        // Link value of the JAL at 0x7C
        expect_store(32'h128, 32'h7C + 32'd4);
        expect_store(32'h12C, 32'd5);
    endtask

    // Instruction memory with a fresh random latency for each address
    always @(posedge clk) begin
        #1;
        if (o_imem_addr != imem_last) begin
            imem_last = o_imem_addr;
            imem_wait = $urandom_range(3, 0);
        end else if (imem_wait != 0) begin
            imem_wait--;
        end
        i_imem_ack   = (imem_wait == 0);
        i_imem_instr = rom[o_imem_addr[7:2]];
    end

    // Data memory with a random ack delay for each request
    always @(posedge clk) begin
        #1;
        // An ack on the last edge finished the access
        if (i_dmem_ack) begin
            dmem_pending = 1'b0;
        end
        if (o_dmem_req === 1'b1 && !dmem_pending) begin
            dmem_pending = 1'b1;
            dmem_wait    = $urandom_range(3, 0);
        end else if (dmem_pending && dmem_wait != 0) begin
            dmem_wait--;
        end
        i_dmem_ack = dmem_pending && (dmem_wait == 0);
        if (i_dmem_ack) begin
            if (o_dmem_we) begin
                ram[o_dmem_addr[9:2]] = o_dmem_wdata;
                check_store(o_dmem_addr, o_dmem_wdata);
            end
            i_dmem_rdata = ram[o_dmem_addr[9:2]];
        end
    end

    initial begin
        int cycles;
        int end_cycles;

        void'($urandom(32'h6a9fa2b6));
        i_reset      = 1'b1;
        i_imem_instr = 32'h0000_0013;
        i_imem_ack   = 1'b0;
        i_dmem_rdata = '0;
        i_dmem_ack   = 1'b0;
        imem_last    = '1;
        imem_wait    = 0;
        dmem_pending = 1'b0;
        dmem_wait    = 0;
        store_idx    = 0;
        errors       = 0;
        timeouts     = 0;
        prog_len     = 0;
        for (int i = 0; i < 64; i++) begin
            rom[i] = 32'h0000_0013;
        end
        for (int i = 0; i < 256; i++) begin
            ram[i] = ram_fill(i * 4);
        end
        build_program();
        build_expected();

        repeat (2) @(posedge clk);
        #1;
        i_reset = 1'b0;

        cycles = 0;
        while (store_idx < exp_addr.size() && cycles < STORE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (store_idx < exp_addr.size()) begin
            $display("Timed out with %0d of %0d stores seen", store_idx, exp_addr.size());
            timeouts++;
        end

        // Let the final loop spin so late shadow stores would show up
        cycles     = 0;
        end_cycles = 0;
        while (end_cycles < DRAIN_CYCLES && cycles < DRAIN_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (o_imem_addr == END_PC) begin
                end_cycles++;
            end
        end
        if (end_cycles < DRAIN_CYCLES) begin
            $display("Timed out waiting for the core to reach its final loop");
            timeouts++;
        end

        $display("errors: %0d  assertion failures: %0d  timeouts: %0d",
                 errors, dut0.asserts0.fail_count, timeouts);
        if (errors == 0 && timeouts == 0 && dut0.asserts0.fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
